// File: timedFlagPkg.sv
`default_nettype none

package timedFlagPkg;

   // Bus and table entry width.
   localparam int defaultDataW = 32;

   // 1024 table entries.
   localparam int defaultAddrW = 10;

   // Cycle counter, start delay and amount.
   localparam int countW = 32;

   // Sequencer states.
   typedef enum logic [1:0] {
      seqIdle  = 2'd0, // Finished or never started.
      seqPrime = 2'd1, // Entry 0 prefetch in flight.
      seqDelay = 2'd2, // Start delay countdown.
      seqCount = 2'd3  // Counting and matching.
   } seqState;

endpackage

`default_nettype wire

// File: timestampTable.sv
`timescale 1ns/100ps
`default_nettype none

module timestampTable import timedFlagPkg::*; #(
   parameter int DATA_W = defaultDataW,
   parameter int ADDR_W = defaultAddrW
) (
   input  wire                  clk,
   input  wire                  rst,

   // Host write port.
   input  wire                  valid,
   input  wire [ADDR_W-1:0]     addr,
   input  wire [DATA_W-1:0]     wdata,
   input  wire [DATA_W/8-1:0]   wstrb,
   output logic                 ready,

   // Scanner read port.
   input  wire [ADDR_W-1:0]     scanAddr,
   input  wire                  scanEnable,
   output logic [DATA_W-1:0]    scanData
);

   localparam int BYTES = DATA_W / 8;
   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   // Byte merge on write.
   always_ff @(posedge clk) begin
      if (valid) begin
         for (int b = 0; b < BYTES; b++) begin
            if (wstrb[b]) begin
               mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
            end
         end
      end
   end

   // Read data holds between enabled reads.
   always_ff @(posedge clk) begin
      if (scanEnable) begin
         scanData <= mem[scanAddr];
      end
   end

   // One cycle write, no back-pressure.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready <= 1'b0;
      end else begin
         ready <= valid;
      end
   end

   // Write and scan read of one entry in one cycle are not arbitrated.
   noScanWriteCollision: assert property (
      @(posedge clk) disable iff (rst)
      !(valid && scanEnable && addr == scanAddr)
   ) else $error("bus write and scan read hit the same entry");

endmodule

`default_nettype wire

// File: timestampScanner.sv
`timescale 1ns/100ps
`default_nettype none

module timestampScanner import timedFlagPkg::*; #(
   parameter int DATA_W = defaultDataW,
   parameter int ADDR_W = defaultAddrW
) (
   input  wire                  clk,
   input  wire                  rst,

   input  wire                  restart,
   input  wire                  advance,

   // Table read port.
   output logic [ADDR_W-1:0]    scanAddr,
   output logic                 scanEnable,
   input  wire [DATA_W-1:0]     scanData,

   output logic [DATA_W-1:0]    currentValue,
   output logic                 valueValid
);

   logic [ADDR_W-1:0] ptr;      // Entry now on scanData.
   logic              hasValue;

   // Prefetch of entry 0, or the next entry on a match.
   assign scanEnable = restart | advance;
   assign scanAddr   = restart ? '0 : ptr + 1'b1;

   assign currentValue = scanData;
   assign valueValid   = hasValue & ~restart; // Old data is stale during prefetch.

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ptr      <= '0;
         hasValue <= 1'b0;
      end else if (restart) begin
         ptr      <= '0;
         hasValue <= 1'b1;
      end else if (advance) begin
         ptr <= ptr + 1'b1;
      end
   end

   advanceNeedsValue: assert property (
      @(posedge clk) disable iff (rst)
      advance |-> valueValid
   ) else $error("advance without a valid current entry");

endmodule

`default_nettype wire

// File: flagSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module flagSequencer import timedFlagPkg::*; (
   input  wire                  clk,
   input  wire                  rst,

   input  wire                  run,
   input  wire                  running,
   input  wire [countW-1:0]     amount,
   input  wire [countW-1:0]     delay0,

   // Scanner side.
   input  wire [countW-1:0]     currentValue,
   input  wire                  valueValid,
   output logic                 restart,
   output logic                 advance,

   output logic                 out0,
   output logic                 done
);

   seqState           state;
   logic [countW-1:0] cycle;
   logic [countW-1:0] delayLeft;
   logic [countW-1:0] remaining;
   logic              match;

   // Compare before the increment.
   assign match = (state == seqCount) && running && valueValid
                  && (cycle == currentValue);

   assign advance = match;
   assign done    = (remaining == '0);

   // Scanner prefetch one cycle after run.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         restart <= 1'b0;
      end else begin
         restart <= run;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= seqIdle;
      end else if (run) begin
         state <= seqPrime; // Restart from any state.
      end else begin
         case (state)
            seqPrime: begin
               if (done) begin
                  state <= seqIdle;
               end else if (delayLeft == '0) begin
                  state <= seqCount;
               end else begin
                  state <= seqDelay;
               end
            end
            seqDelay: begin
               if (delayLeft == countW'(1)) begin
                  state <= seqCount;
               end
            end
            seqCount: begin
               if (match && remaining == countW'(1)) begin
                  state <= seqIdle;
               end
            end
            default: state <= seqIdle;
         endcase
      end
   end

   // Start delay runs whether or not running is high.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delayLeft <= '0;
      end else if (run) begin
         delayLeft <= delay0;
      end else if (state == seqDelay) begin
         delayLeft <= delayLeft - 1'b1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cycle <= '0;
      end else if (run) begin
         cycle <= '0;
      end else if (state == seqCount && running) begin
         cycle <= cycle + 1'b1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         remaining <= '0;
      end else if (run) begin
         remaining <= amount;
      end else if (match) begin
         remaining <= remaining - 1'b1;
      end
   end

   // A match in the run cycle belongs to the old sequence.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out0 <= 1'b0;
      end else begin
         out0 <= match & ~run;
      end
   end

   pulseOnlyWhileActive: assert property (
      @(posedge clk) disable iff (rst)
      $rose(out0) |-> $past(!done)
   ) else $error("out0 rose while the sequence was done");

endmodule

`default_nettype wire

// File: timedFlagUnit.sv
`timescale 1ns/100ps
`default_nettype none

module timedFlagUnit import timedFlagPkg::*; #(
   parameter int DATA_W = defaultDataW,
   parameter int ADDR_W = defaultAddrW
) (
   input  wire                  clk,
   input  wire                  rst,

   input  wire                  run,
   input  wire                  running,
   input  wire [countW-1:0]     amount,
   input  wire [countW-1:0]     delay0,

   // Host data bus, write only.
   input  wire                  valid,
   input  wire [ADDR_W-1:0]     addr,
   input  wire [DATA_W-1:0]     wdata,
   input  wire [DATA_W/8-1:0]   wstrb,
   output logic                 ready,

   output logic                 out0,
   output logic                 done
);

   logic [ADDR_W-1:0] scanAddr;
   logic              scanEnable;
   logic [DATA_W-1:0] scanData;
   logic [DATA_W-1:0] currentValue;
   logic              valueValid;
   logic              restart;
   logic              advance;

   // Entries are compared directly against the cycle counter.
   if (DATA_W != countW) begin : gWidthCheck
      $error("DATA_W must equal countW");
   end

   timestampTable #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W)
   ) table0 (
      .clk        (clk),
      .rst        (rst),
      .valid      (valid),
      .addr       (addr),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .ready      (ready),
      .scanAddr   (scanAddr),
      .scanEnable (scanEnable),
      .scanData   (scanData)
   );

   timestampScanner #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W)
   ) scanner0 (
      .clk          (clk),
      .rst          (rst),
      .restart      (restart),
      .advance      (advance),
      .scanAddr     (scanAddr),
      .scanEnable   (scanEnable),
      .scanData     (scanData),
      .currentValue (currentValue),
      .valueValid   (valueValid)
   );

   flagSequencer sequencer0 (
      .clk          (clk),
      .rst          (rst),
      .run          (run),
      .running      (running),
      .amount       (amount),
      .delay0       (delay0),
      .currentValue (currentValue),
      .valueValid   (valueValid),
      .restart      (restart),
      .advance      (advance),
      .out0         (out0),
      .done         (done)
   );

endmodule

`default_nettype wire

// File: timedFlagChecker.sv
`timescale 1ns/100ps
`default_nettype none

module timedFlagChecker (
   input  wire  clk,

   // DUT outputs.
   input  wire  out0,
   input  wire  done,
   input  wire  ready,

   // Expected values for the current cycle.
   input  wire  expOut0,
   input  wire  expDone,
   input  wire  expReady,

   output int   errors
);

   int count = 0;

   assign errors = count;

   task automatic compareBit(input string name, input logic got, input logic want);
      if (got !== want) begin
         count++;
         $display("error at %0d ns: %s is %b, expected %b", $time, name, got, want);
      end
   endtask

   // Outputs are settled by the falling edge.
   always @(negedge clk) begin
      compareBit("out0", out0, expOut0);
      compareBit("done", done, expDone);
      compareBit("ready", ready, expReady);
   end

endmodule

`default_nettype wire

// File: timedFlagTb.sv
`timescale 1ns/100ps
`default_nettype none

module timedFlagTb import timedFlagPkg::*; ();

   localparam int MAXC = 8192; // Cycles covered by the expected maps.
   localparam int NENT = 24;   // Table entries written.

   logic                      clk = 1'b0;
   logic                      rst = 1'b1;
   logic                      run = 1'b0;
   logic                      running = 1'b0;
   logic                      valid = 1'b0;
   logic [defaultAddrW-1:0]   addr = '0;
   logic [defaultDataW-1:0]   wdata = '0;
   logic [defaultDataW/8-1:0] wstrb = '0;
   logic [countW-1:0]         amount = '0;
   logic [countW-1:0]         delay0 = '0;
   logic                      ready;
   logic                      out0;
   logic                      done;

   logic        expOut0 = 1'b0;
   logic        expDone = 1'b1;
   logic        expReady = 1'b0;
   int          errors;
   int          timeouts = 0;
   int          cyc = 0;      // Index of the current clock cycle.
   int          runCycle = 0;
   logic [31:0] seed = 32'h417d08c8;

   logic [31:0] target [NENT];
   logic [31:0] modelMem [NENT]; // Table as the host writes it.
   bit          runAt [MAXC];
   bit          outMap [MAXC];
   bit          doneMap [MAXC];
   bit          readyMap [MAXC];

   timedFlagUnit #(
      .DATA_W (defaultDataW),
      .ADDR_W (defaultAddrW)
   ) UUT (
      .clk     (clk),
      .rst     (rst),
      .run     (run),
      .running (running),
      .amount  (amount),
      .delay0  (delay0),
      .valid   (valid),
      .addr    (addr),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .ready   (ready),
      .out0    (out0),
      .done    (done)
   );

   timedFlagChecker monitor0 (
      .clk      (clk),
      .out0     (out0),
      .done     (done),
      .ready    (ready),
      .expOut0  (expOut0),
      .expDone  (expDone),
      .expReady (expReady),
      .errors   (errors)
   );

   initial begin
      forever #20 clk = ~clk;
   end

   // Next cycle's stimulus and expected values.
   always @(posedge clk) begin
      cyc      <= cyc + 1;
      running  <= runAt[cyc + 1];
      expOut0  <= outMap[cyc + 1];
      expDone  <= doneMap[cyc + 1];
      expReady <= readyMap[cyc + 1];
   end

   function automatic logic [31:0] nextRand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic int randBelow(input int n);
      logic [31:0] r;
      r = nextRand();
      return int'(r[31:16] % n);
   endfunction

   function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
      logic [31:0] r;
      r = old;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            r[b*8 +: 8] = data[b*8 +: 8];
         end
      end
      return r;
   endfunction

   task automatic idleCycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic writeWord(input logic [defaultAddrW-1:0] a, input logic [31:0] d,
                            input logic [3:0] s);
      @(negedge clk);
      readyMap[cyc + 2] = 1'b1; // Valid lands in cyc+1.
      modelMem[a] = mergeBytes(modelMem[a], d, s);
      @(posedge clk);
      valid <= 1'b1;
      addr  <= a;
      wdata <= d;
      wstrb <= s;
   endtask

   task automatic releaseBus();
      @(posedge clk);
      valid <= 1'b0;
   endtask

   // Builds the expected maps for a run issued in cycle t, then issues it.
   task automatic startRun(input int amt, input int dly, input bit pauses);
      int          t;
      int          c;
      int          idx;
      logic [31:0] cnt;
      @(negedge clk);
      t = cyc + 1;
      for (c = t + 1; c < MAXC; c++) begin
         runAt[c]  = pauses ? (randBelow(4) != 0) : 1'b1;
         outMap[c] = 1'b0;  // Drops pulses of an interrupted run.
      end
      c = t + 2 + dly;  // First counting cycle.
      cnt = '0;
      idx = 0;
      while (idx < amt && c < MAXC - 1) begin
         if (runAt[c]) begin
            if (cnt == modelMem[idx]) begin
               outMap[c + 1] = 1'b1;
               idx++;
            end
            cnt++;
         end
         c++;
      end
      for (int x = t + 1; x < MAXC; x++) begin
         doneMap[x] = (amt == 0) || (x >= c);
      end
      runCycle = t;
      @(posedge clk);
      run    <= 1'b1;
      amount <= countW'(amt);
      delay0 <= countW'(dly);
      @(posedge clk);
      run <= 1'b0;
   endtask

   task automatic waitDone(input int limit);
      int n;
      n = 0;
      @(negedge clk);
      while ((cyc <= runCycle + 1 || done !== 1'b1) && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (done !== 1'b1) begin
         timeouts++;
         $display("timeout: done did not rise within %0d cycles of run", limit);
      end
      idleCycles(4);
   endtask

   initial begin
      #((MAXC - 4) * 40);
      $display("timeout: simulation ran past the expected-value maps");
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      int          acc;
      logic [3:0]  m;
      logic [31:0] bm;
      logic [31:0] junk;
      for (int c = 0; c < MAXC; c++) begin
         doneMap[c] = 1'b1;
      end
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      idleCycles(3);

      // Each entry gets junk, then two partial writes that only merge right.
      acc = 0;
      for (int i = 0; i < NENT; i++) begin
         acc = acc + randBelow(8) + 1;
         target[i] = 32'(acc);
         m = 4'(randBelow(14) + 1);
         bm = {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
         junk = nextRand();
         writeWord(defaultAddrW'(i), nextRand(), 4'hf);
         writeWord(defaultAddrW'(i), (target[i] & ~bm) | (junk & bm), ~m);
         writeWord(defaultAddrW'(i), (target[i] & bm) | (junk & ~bm), m);
      end
      releaseBus();
      idleCycles(3);

      startRun(NENT, 0, 1'b0);
      waitDone(2000);
      startRun(NENT, 1, 1'b0);
      waitDone(2000);
      startRun(NENT, 5, 1'b0);
      waitDone(2000);

      repeat (3) begin
         startRun(NENT, randBelow(12), 1'b1);
         waitDone(2000);
      end

      startRun(0, 4, 1'b0);
      waitDone(50);
      startRun(5, randBelow(12), 1'b1);
      waitDone(2000);

      // Restart while pulses are still pending.
      repeat (2) begin
         startRun(NENT, randBelow(12), 1'b1);
         idleCycles(randBelow(80) + 10);
         startRun(randBelow(NENT) + 1, randBelow(12), 1'b1);
         waitDone(2000);
      end

      idleCycles(5);
      $display("mismatches: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
timedFlagPkg.sv
timestampTable.sv
timestampScanner.sv
flagSequencer.sv
timedFlagUnit.sv
timedFlagChecker.sv
timedFlagTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert --top-module timedFlagTb -f sim.f \
      -Mdir obj_dir -o timedFlagSim \
   && ./obj_dir/timedFlagSim | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed"; exit 1; }
